// ==== sim.f ====
src/bus_pkg.sv
src/dma_pkg.sv
src/dma_regs.sv
src/dma_engine.sv
src/bus_arbiter.sv
src/word_mem.sv
src/dma_subsystem.sv
tests/tb_dma_subsystem.sv

// ==== tests/tb_dma_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dma_subsystem
    import bus_pkg::*, dma_pkg::*;
;

    localparam int MEM_WORDS   = 1024;
    localparam int ACK_TIMEOUT = 200;
    localparam int IRQ_TIMEOUT = 5000;

    logic      clk;
    logic      rst;
    logic      cfg_cyc;
    logic      cfg_stb;
    logic      cfg_we;
    cfg_addr_t cfg_adr;
    data_t     cfg_dat_w;
    data_t     cfg_dat_r;
    logic      cfg_ack;
    logic      cpu_cyc;
    logic      cpu_stb;
    logic      cpu_we;
    addr_t     cpu_adr;
    data_t     cpu_dat_w;
    data_t     cpu_dat_r;
    logic      cpu_ack;
    logic      irq;

    data_t model [0:MEM_WORDS-1];        // expected memory contents indexed by word.
    int    seed = 62;
    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    checks;

    dma_subsystem #(
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .cfg_cyc   (cfg_cyc),
        .cfg_stb   (cfg_stb),
        .cfg_we    (cfg_we),
        .cfg_adr   (cfg_adr),
        .cfg_dat_w (cfg_dat_w),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic data_t ctrl_value(input irq_cause_t cause, input logic busy);
        data_t v;
        v      = '0;
        v[0]   = busy;                   // busy sits in bit 0 and the cause just above it.
        v[2:1] = cause;
        return v;
    endfunction

    task automatic check(input string what, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic wait_cfg_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cfg_ack && n < ACK_TIMEOUT);
        if (!cfg_ack) begin
            $display("%s: configuration port gave no acknowledge in time", test_name);
            errors++;
        end
    endtask

    task automatic wait_cpu_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cpu_ack && n < ACK_TIMEOUT);
        if (!cpu_ack) begin
            $display("%s: memory port gave no acknowledge in time", test_name);
            errors++;
        end
    endtask

    task automatic cfg_write(input cfg_addr_t adr, input data_t dat);
        @(posedge clk);
        cfg_cyc   <= 1'b1;
        cfg_stb   <= 1'b1;
        cfg_we    <= 1'b1;
        cfg_adr   <= adr;
        cfg_dat_w <= dat;
        wait_cfg_ack();
        cfg_cyc <= 1'b0;
        cfg_stb <= 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t adr, output data_t dat);
        @(posedge clk);
        cfg_cyc <= 1'b1;
        cfg_stb <= 1'b1;
        cfg_we  <= 1'b0;
        cfg_adr <= adr;
        wait_cfg_ack();
        dat = cfg_dat_r;                 // registered data is valid with ack.
        cfg_cyc <= 1'b0;
        cfg_stb <= 1'b0;
    endtask

    task automatic mem_write(input addr_t adr, input data_t dat);
        @(posedge clk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= 1'b1;
        cpu_adr   <= adr;
        cpu_dat_w <= dat;
        wait_cpu_ack();
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
    endtask

    task automatic mem_read(input addr_t adr, output data_t dat);
        @(posedge clk);
        cpu_cyc <= 1'b1;
        cpu_stb <= 1'b1;
        cpu_we  <= 1'b0;
        cpu_adr <= adr;
        wait_cpu_ack();
        dat = cpu_dat_r;
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (!irq && n < IRQ_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!irq) begin
            $display("%s: timed out waiting for the interrupt", test_name);
            errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (irq) begin
                $display("%s: an unexpected interrupt was raised", test_name);
                errors++;
                break;
            end
        end
    endtask

    task automatic fill_range(input addr_t base, input int words);
        data_t d;
        for (int i = 0; i < words; i++) begin
            d = data_t'($random(seed));
            model[base / WORD_BYTES + i] = d;
            mem_write(addr_t'(base + i * WORD_BYTES), d);
        end
    endtask

    task automatic verify_range(input addr_t base, input int words);
        data_t d;
        addr_t a;
        for (int i = 0; i < words; i++) begin
            a = addr_t'(base + i * WORD_BYTES);
            mem_read(a, d);
            check($sformatf("word %h", a), model[a / WORD_BYTES], d);
        end
    endtask

    // the engine copies whole words upward from the lowest address.
    task automatic copy_model(input addr_t src, input addr_t dst, input addr_t len);
        for (int i = 0; i < len / WORD_BYTES; i++) begin
            model[dst / WORD_BYTES + i] = model[src / WORD_BYTES + i];
        end
    endtask

    task automatic program_copy(input addr_t src, input addr_t dst, input addr_t len);
        cfg_write(REG_SRC, data_t'(src));
        cfg_write(REG_DST, data_t'(dst));
        cfg_write(REG_LEN, data_t'(len));
        cfg_write(REG_CTRL, 32'h1);
    endtask

    task automatic finish_copy(input string what);
        data_t d;
        wait_irq();
        cfg_read(REG_CTRL, d);
        check({what, " status"}, ctrl_value(IRQ_DONE, 1'b0), d);
        cfg_write(REG_IRQ_CLR, '0);
    endtask

    task automatic test_register_readback();
        data_t d;
        begin_test("register readback");
        cfg_read(REG_CTRL, d);
        check("ctrl after reset", ctrl_value(IRQ_NONE, 1'b0), d);
        check("irq after reset", '0, data_t'(irq));
        cfg_write(REG_SRC, 32'h0000_1234);
        cfg_write(REG_DST, 32'h0000_0abc);
        cfg_write(REG_LEN, 32'h0000_0040);
        cfg_read(REG_SRC, d);
        check("src", 32'h0000_1234, d);
        cfg_read(REG_DST, d);
        check("dst", 32'h0000_0abc, d);
        cfg_read(REG_LEN, d);
        check("len", 32'h0000_0040, d);
        end_test();
    endtask

    task automatic test_basic_copy();
        data_t d;
        begin_test("basic copy");
        fill_range(16'h0100, 16);
        fill_range(16'h0200, 18);        // two guard words past the destination.
        program_copy(16'h0100, 16'h0200, 16'd64);
        wait_irq();
        cfg_read(REG_CTRL, d);
        check("ctrl when done", ctrl_value(IRQ_DONE, 1'b0), d);
        copy_model(16'h0100, 16'h0200, 16'd64);
        verify_range(16'h0200, 18);
        end_test();
    endtask

    task automatic test_irq_clear();
        data_t d;
        begin_test("interrupt clear");
        cfg_write(REG_IRQ_CLR, '0);
        check("irq after clear", '0, data_t'(irq));
        cfg_read(REG_CTRL, d);
        check("ctrl after clear", ctrl_value(IRQ_NONE, 1'b0), d);
        fill_range(16'h0300, 8);
        program_copy(16'h0100, 16'h0300, 16'd24);
        finish_copy("second copy");
        copy_model(16'h0100, 16'h0300, 16'd24);
        verify_range(16'h0300, 8);
        end_test();
    endtask

    task automatic reject_case(input string what, input addr_t src, input addr_t dst,
                               input addr_t len);
        data_t d;
        program_copy(src, dst, len);
        cfg_read(REG_CTRL, d);
        check({what, " status"}, ctrl_value(IRQ_ERROR, 1'b0), d);
        check({what, " irq"}, 32'h1, data_t'(irq));
        cfg_write(REG_IRQ_CLR, '0);
    endtask

    task automatic test_rejected_starts();
        addr_t past;
        past = addr_t'(MEM_WORDS * WORD_BYTES - 8);
        begin_test("rejected starts");
        reject_case("zero length", 16'h0100, 16'h0300, 16'd0);
        reject_case("unaligned length", 16'h0100, 16'h0300, 16'd6);
        reject_case("unaligned source", 16'h0102, 16'h0300, 16'd16);
        reject_case("unaligned destination", 16'h0100, 16'h0302, 16'd16);
        reject_case("source past end", past, 16'h0300, 16'd16);
        reject_case("destination past end", 16'h0100, past, 16'd16);
        verify_range(16'h0300, 8);
        verify_range(16'h0100, 16);
        end_test();
    endtask

    task automatic test_contention();
        data_t d;
        data_t v;
        begin_test("contention");
        fill_range(16'h0400, 64);
        fill_range(16'h0800, 64);
        program_copy(16'h0400, 16'h0800, 16'd256);
        for (int i = 0; i < 4; i++) begin
            v = data_t'($random(seed));
            model[16'h0c00 / WORD_BYTES] = v;
            mem_write(16'h0c00, v);
            mem_read(16'h0c00, d);
            check("cpu word during copy", v, d);
        end
        cfg_read(REG_CTRL, d);
        check("still busy", 32'h1, d & 32'h1);   // the CPU accesses must fall inside the copy.
        finish_copy("long copy");
        copy_model(16'h0400, 16'h0800, 16'd256);
        verify_range(16'h0800, 64);
        verify_range(16'h0c00, 1);
        end_test();
    endtask

    task automatic test_start_while_busy();
        data_t d;
        begin_test("start while busy");
        fill_range(16'h0a00, 16);
        fill_range(16'h0b00, 16);
        program_copy(16'h0100, 16'h0a00, 16'd64);
        cfg_read(REG_CTRL, d);
        check("busy bit", 32'h1, d & 32'h1);
        cfg_write(REG_DST, 32'h0000_0b00);
        cfg_write(REG_CTRL, 32'h1);
        cfg_read(REG_DST, d);
        check("dst held while busy", 32'h0000_0a00, d);
        finish_copy("first copy");
        expect_quiet(200);               // a second transfer would raise irq again.
        copy_model(16'h0100, 16'h0a00, 16'd64);
        verify_range(16'h0a00, 16);
        verify_range(16'h0b00, 16);
        end_test();
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        rst       <= 1'b1;
        cfg_cyc   <= 1'b0;
        cfg_stb   <= 1'b0;
        cfg_we    <= 1'b0;
        cfg_adr   <= '0;
        cfg_dat_w <= '0;
        cpu_cyc   <= 1'b0;
        cpu_stb   <= 1'b0;
        cpu_we    <= 1'b0;
        cpu_adr   <= '0;
        cpu_dat_w <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_register_readback();
        test_basic_copy();
        test_irq_clear();
        test_rejected_starts();
        test_contention();
        test_start_while_busy();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/dma_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_subsystem
    import bus_pkg::*, dma_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      cfg_cyc,
    input  wire logic      cfg_stb,
    input  wire logic      cfg_we,
    input  wire cfg_addr_t cfg_adr,
    input  wire data_t     cfg_dat_w,
    output data_t          cfg_dat_r,
    output logic           cfg_ack,
    input  wire logic      cpu_cyc,
    input  wire logic      cpu_stb,
    input  wire logic      cpu_we,
    input  wire addr_t     cpu_adr,
    input  wire data_t     cpu_dat_w,
    output data_t          cpu_dat_r,
    output logic           cpu_ack,
    output logic           irq
);

    logic  start;
    logic  busy;
    logic  done;
    addr_t src_addr;
    addr_t dst_addr;
    addr_t length;

    logic  dma_cyc;
    logic  dma_stb;
    logic  dma_we;
    addr_t dma_adr;
    data_t dma_dat_w;
    data_t dma_dat_r;
    logic  dma_ack;
    logic  dma_gnt;

    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    data_t mem_dat_w;
    data_t mem_dat_r;
    logic  mem_ack;

    dma_regs #(
        .MEM_WORDS (MEM_WORDS)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_cyc   (cfg_cyc),
        .cfg_stb   (cfg_stb),
        .cfg_we    (cfg_we),
        .cfg_adr   (cfg_adr),
        .cfg_dat_w (cfg_dat_w),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .irq       (irq),
        .src_addr  (src_addr),
        .dst_addr  (dst_addr),
        .length    (length)
    );

    dma_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .src_addr  (src_addr),
        .dst_addr  (dst_addr),
        .length    (length),
        .busy      (busy),
        .done      (done),
        .dma_cyc   (dma_cyc),
        .dma_stb   (dma_stb),
        .dma_we    (dma_we),
        .dma_adr   (dma_adr),
        .dma_dat_w (dma_dat_w),
        .dma_dat_r (dma_dat_r),
        .dma_ack   (dma_ack),
        .dma_gnt   (dma_gnt)
    );

    bus_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .dma_cyc   (dma_cyc),
        .dma_stb   (dma_stb),
        .dma_we    (dma_we),
        .dma_adr   (dma_adr),
        .dma_dat_w (dma_dat_w),
        .dma_dat_r (dma_dat_r),
        .dma_ack   (dma_ack),
        .dma_gnt   (dma_gnt),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    word_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

endmodule

`default_nettype wire

// ==== src/word_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_mem
    import bus_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  mem_cyc,
    input  wire logic  mem_stb,
    input  wire logic  mem_we,
    input  wire addr_t mem_adr,
    input  wire data_t mem_dat_w,
    output data_t      mem_dat_r,
    output logic       mem_ack
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t            mem [0:MEM_WORDS-1];
    logic             req;
    logic [IDX_W-1:0] idx;

    assign req = mem_cyc && mem_stb && !mem_ack;     // one access per request.
    assign idx = IDX_W'(mem_adr / WORD_BYTES);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (mem_we) begin
                mem[idx] <= mem_dat_w;
            end else begin
                mem_dat_r <= mem[idx];           // valid in the ack cycle.
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  cpu_cyc,
    input  wire logic  cpu_stb,
    input  wire logic  cpu_we,
    input  wire addr_t cpu_adr,
    input  wire data_t cpu_dat_w,
    output data_t      cpu_dat_r,
    output logic       cpu_ack,
    input  wire logic  dma_cyc,
    input  wire logic  dma_stb,
    input  wire logic  dma_we,
    input  wire addr_t dma_adr,
    input  wire data_t dma_dat_w,
    output data_t      dma_dat_r,
    output logic       dma_ack,
    output logic       dma_gnt,
    output logic       mem_cyc,
    output logic       mem_stb,
    output logic       mem_we,
    output addr_t      mem_adr,
    output data_t      mem_dat_w,
    input  wire data_t mem_dat_r,
    input  wire logic  mem_ack
);

    logic dma_owner;                     // low means the CPU port owns the memory.
    logic owner_cyc;

    assign owner_cyc = dma_owner ? dma_cyc : cpu_cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_owner <= 1'b0;
        end else if (!owner_cyc) begin
            if (dma_cyc) begin
                dma_owner <= 1'b1;       // the engine wins a tie.
            end else if (cpu_cyc) begin
                dma_owner <= 1'b0;
            end
        end
    end

    assign dma_gnt = dma_owner;

    assign mem_cyc   = dma_owner ? dma_cyc   : cpu_cyc;
    assign mem_stb   = dma_owner ? dma_stb   : cpu_stb;
    assign mem_we    = dma_owner ? dma_we    : cpu_we;
    assign mem_adr   = dma_owner ? dma_adr   : cpu_adr;
    assign mem_dat_w = dma_owner ? dma_dat_w : cpu_dat_w;

    // Read data goes to both; only the owner gets an ack.
    assign cpu_dat_r = mem_dat_r;
    assign dma_dat_r = mem_dat_r;
    assign cpu_ack   = !dma_owner && mem_ack;
    assign dma_ack   = dma_owner && mem_ack;

endmodule

`default_nettype wire

// ==== src/dma_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_engine
    import bus_pkg::*, dma_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire addr_t src_addr,
    input  wire addr_t dst_addr,
    input  wire addr_t length,
    output logic       busy,
    output logic       done,
    output logic       dma_cyc,
    output logic       dma_stb,
    output logic       dma_we,
    output addr_t      dma_adr,
    output data_t      dma_dat_w,
    input  wire data_t dma_dat_r,
    input  wire logic  dma_ack,
    input  wire logic  dma_gnt
);

    dma_state_t state;
    addr_t      offset;                  // bytes already copied.
    addr_t      next_offset;
    data_t      data_q;                  // word in flight between read and write.

    assign next_offset = offset + addr_t'(WORD_BYTES);

    assign busy = (state != ST_IDLE);

    // The bus is held from the request until the write is acknowledged.
    assign dma_cyc = (state == ST_REQ) || (state == ST_READ) || (state == ST_WRITE);
    assign dma_stb = (state == ST_READ) || (state == ST_WRITE);
    assign dma_we  = (state == ST_WRITE);

    assign dma_adr   = (state == ST_WRITE) ? dst_addr + offset : src_addr + offset;
    assign dma_dat_w = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            offset <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        offset <= '0;
                        state  <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (dma_gnt) state <= ST_READ;    // grant can stay from the last word.
                end
                ST_READ: begin
                    if (dma_ack) state <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (dma_ack) begin
                        offset <= next_offset;
                        if (next_offset == length) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_GAP;
                        end
                    end
                end
                ST_GAP: begin
                    // cyc is low here, so a waiting CPU takes the bus.
                    state <= ST_REQ;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_READ) && dma_ack) begin
            data_q <= dma_dat_r;
        end
    end

endmodule

`default_nettype wire

// ==== src/dma_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_regs
    import bus_pkg::*, dma_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      cfg_cyc,
    input  wire logic      cfg_stb,
    input  wire logic      cfg_we,
    input  wire cfg_addr_t cfg_adr,
    input  wire data_t     cfg_dat_w,
    output data_t          cfg_dat_r,
    output logic           cfg_ack,
    input  wire logic      busy,
    input  wire logic      done,
    output logic           start,
    output logic           irq,
    output addr_t          src_addr,
    output addr_t          dst_addr,
    output addr_t          length
);

    // one past the last byte of the memory; needs a bit more than an address.
    localparam logic [ADDR_W:0] MEM_LIMIT = (ADDR_W + 1)'(MEM_WORDS * WORD_BYTES);

    irq_cause_t      cause;
    logic            req;
    logic            locked;
    logic            start_ok;
    logic [ADDR_W:0] src_end;
    logic [ADDR_W:0] dst_end;

    assign req    = cfg_cyc && cfg_stb && !cfg_ack;   // ack drops the request for a cycle.
    assign locked = busy || start;                     // the engine has not left idle yet on start.
    assign irq    = (cause != IRQ_NONE);

    assign src_end = {1'b0, src_addr} + {1'b0, length};
    assign dst_end = {1'b0, dst_addr} + {1'b0, length};

    assign start_ok = (length != '0) &&
                      ((src_addr % WORD_BYTES) == 0) &&
                      ((dst_addr % WORD_BYTES) == 0) &&
                      ((length % WORD_BYTES) == 0) &&
                      (src_end <= MEM_LIMIT) &&
                      (dst_end <= MEM_LIMIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_ack  <= 1'b0;
            start    <= 1'b0;
            cause    <= IRQ_NONE;
            src_addr <= '0;
            dst_addr <= '0;
            length   <= '0;
        end else begin
            cfg_ack <= req;
            start   <= 1'b0;
            if (req && cfg_we) begin
                case (cfg_adr)
                    REG_SRC: begin
                        if (!locked) src_addr <= cfg_dat_w[ADDR_W-1:0];
                    end
                    REG_DST: begin
                        if (!locked) dst_addr <= cfg_dat_w[ADDR_W-1:0];
                    end
                    REG_LEN: begin
                        if (!locked) length <= cfg_dat_w[ADDR_W-1:0];
                    end
                    REG_CTRL: begin
                        if (cfg_dat_w[0] && !locked) begin
                            if (start_ok) begin
                                start <= 1'b1;       // lines up with the ack of this write.
                            end else begin
                                cause <= IRQ_ERROR;
                            end
                        end
                    end
                    REG_IRQ_CLR: cause <= IRQ_NONE;
                    default: ;
                endcase
            end
            // A finishing transfer is never lost to a clear in the same cycle.
            if (done) cause <= IRQ_DONE;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !cfg_we) begin
            case (cfg_adr)
                REG_SRC:  cfg_dat_r <= data_t'(src_addr);
                REG_DST:  cfg_dat_r <= data_t'(dst_addr);
                REG_LEN:  cfg_dat_r <= data_t'(length);
                REG_CTRL: cfg_dat_r <= data_t'({cause, busy});
                default:  cfg_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    typedef logic [4:0] cfg_addr_t;      // byte offset on the configuration port.

    localparam cfg_addr_t REG_SRC     = 5'h00;
    localparam cfg_addr_t REG_DST     = 5'h04;
    localparam cfg_addr_t REG_LEN     = 5'h08;
    localparam cfg_addr_t REG_CTRL    = 5'h0C;   // writing bit 0 starts and reading gives {cause, busy}.
    localparam cfg_addr_t REG_IRQ_CLR = 5'h10;   // any write clears the cause.

    typedef enum logic [1:0] {
        IRQ_NONE  = 2'd0,
        IRQ_DONE  = 2'd1,
        IRQ_ERROR = 2'd2
    } irq_cause_t;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_REQ   = 3'd1,                 // cyc is raised while the engine waits for the grant.
        ST_READ  = 3'd2,
        ST_WRITE = 3'd3,
        ST_GAP   = 3'd4                  // cyc low for one cycle between words.
    } dma_state_t;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 16;          // byte address width on every bus port.
    localparam int DATA_W = 32;          // one memory word.

    // a word is the unit of every transfer and the alignment unit.
    localparam int WORD_BYTES = DATA_W / 8;

    // byte address on the configuration, CPU, DMA and memory ports.
    typedef logic [ADDR_W-1:0] addr_t;

    // one data word on every bus.
    typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire
